/* Makefile */
TOOL       = verilator
TOP        = tb_scanline
FILELIST   = list.f
FLAGS      = --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)

run: build
	-./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* cmd_in/cmd_deser.sv */
//##########################################################################
// command deserializer: six bytes in, address/data word out on a match
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module cmd_deser #(
    parameter logic [15:0] CMD_BASE = 16'h0120,
    parameter logic [15:0] CMD_MASK = 16'h03f0
) (
    input  wire                     rst,       // clock
    input  wire                     mclk,      // async reset
    input  wire [7:0]               cmd_ad,
    input  wire                     cmd_stb,   // comes with address low byte
    output logic [3:0]              cmd_a,
    output scanline_pkg::cmd_word_u cmd_data,
    output logic                    cmd_we
);

    logic [47:0] sr;        // bytes enter at the top, AL ends at the bottom
    logic [2:0]  byte_cnt;  // bytes taken so far, 0 when idle
    logic        last_byte;
    logic        addr_hit;

    assign last_byte = (byte_cnt == 3'd5) && !cmd_stb;
    // AL/AH sit one byte higher until the last shift
    assign addr_hit  = ((sr[23:8] ^ CMD_BASE) & CMD_MASK) == 16'h0000;
    assign cmd_a     = sr[3:0];
    assign cmd_data  = sr[47:16];  // D0 lowest

    always_ff @(posedge rst) begin
        if (cmd_stb || (byte_cnt != 3'd0))
            sr <= {cmd_ad, sr[47:8]};
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            byte_cnt <= 3'd0;
            cmd_we   <= 1'b0;
        end else begin
            cmd_we <= last_byte && addr_hit;
            if (cmd_stb)
                byte_cnt <= 3'd1;                 // restart on any strobe
            else if (last_byte)
                byte_cnt <= 3'd0;
            else if (byte_cnt != 3'd0)
                byte_cnt <= byte_cnt + 3'd1;
        end
    end

    // a write needs six fresh bytes, so strobes never touch
    a_we_single : assert property (@(posedge rst) disable iff (mclk) cmd_we |=> !cmd_we);

endmodule

`default_nettype wire

/* cmd_in/scanline_regs.sv */
//##########################################################################
// channel register file: frame layout, window, start point and mode decode
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module scanline_regs (
    input  wire                     rst,       // clock
    input  wire                     mclk,      // async reset
    input  wire [3:0]               cmd_a,
    input  wire scanline_pkg::cmd_word_u cmd_data,
    input  wire                     cmd_we,
    output scanline_pkg::scan_cfg_t cfg,
    output logic                    param_wr   // any write, one cycle late
);

    logic [3:0]                         mode_reg;
    logic [scanline_pkg::RC_BITS-1:0]   start_addr;
    logic [scanline_pkg::FW_BITS:0]     full_width;
    logic [scanline_pkg::FW_BITS:0]     win_width;
    logic [scanline_pkg::FH_BITS:0]     win_height;
    logic [scanline_pkg::FW_BITS-1:0]   win_x0;
    logic [scanline_pkg::FH_BITS-1:0]   win_y0;
    logic [scanline_pkg::FW_BITS-1:0]   start_x;
    logic [scanline_pkg::FH_BITS-1:0]   start_y;
    logic                               x_zero;  // low 13 bits clear, load as 0x2000
    logic                               y_zero;  // upper half clear, load as 0x10000

    assign x_zero = cmd_data.xy.x[scanline_pkg::FW_BITS-1:0] == '0;
    assign y_zero = cmd_data.xy.y == '0;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            mode_reg   <= '0;  // channel held in reset
            start_addr <= '0;
            full_width <= '0;
            win_width  <= 14'h2000;
            win_height <= 17'h10000;
            win_x0     <= '0;
            win_y0     <= '0;
            start_x    <= '0;
            start_y    <= '0;
            param_wr   <= 1'b0;
        end else begin
            param_wr <= cmd_we;
            if (cmd_we) begin
                case (cmd_a)
                    scanline_pkg::REG_MODE:       mode_reg   <= cmd_data.word[3:0];
                    scanline_pkg::REG_START_ADDR:
                        start_addr <= cmd_data.word[scanline_pkg::RC_BITS-1:0];
                    scanline_pkg::REG_FULL_WIDTH:
                        full_width <= {x_zero, cmd_data.xy.x[scanline_pkg::FW_BITS-1:0]};
                    scanline_pkg::REG_WINDOW_WH: begin
                        win_width  <= {x_zero, cmd_data.xy.x[scanline_pkg::FW_BITS-1:0]};
                        win_height <= {y_zero, cmd_data.xy.y};
                    end
                    scanline_pkg::REG_WINDOW_X0Y0: begin
                        win_x0 <= cmd_data.xy.x[scanline_pkg::FW_BITS-1:0];
                        win_y0 <= cmd_data.xy.y;
                    end
                    scanline_pkg::REG_START_XY: begin
                        start_x <= cmd_data.xy.x[scanline_pkg::FW_BITS-1:0];
                        start_y <= cmd_data.xy.y;
                    end
                    default: ;  // unused selects ignored
                endcase
            end
        end
    end

    always_comb begin
        cfg.start_addr  = start_addr;
        cfg.full_width  = full_width;
        cfg.win_width   = win_width;
        cfg.win_height  = win_height;
        cfg.win_x0      = win_x0;
        cfg.win_y0      = win_y0;
        cfg.start_x     = start_x;
        cfg.start_y     = start_y;
        cfg.chn_en      = &mode_reg[1:0];  // enabled and out of reset
        cfg.chn_rst     = ~mode_reg[0];
        cfg.extra_pages = mode_reg[3:2];
    end

endmodule

`default_nettype wire

/* common/scanline_pkg.sv */
//##########################################################################
// scan-line channel package: widths, register selects, command and bus types
//##########################################################################
`default_nettype none

package scanline_pkg;

    localparam int ADDR_ROW_BITS = 15;                         // memory row address
    localparam int COL_BITS      = 10;                         // full column address
    localparam int COL8_BITS     = COL_BITS - 3;               // column in 8-bursts
    localparam int RC_BITS       = ADDR_ROW_BITS + COL8_BITS;  // {row, col8}, bank is separate
    localparam int XFER_BITS     = 6;                          // length field, 0 stands for 64
    localparam int FW_BITS       = 13;                         // frame width in bursts
    localparam int FH_BITS       = 16;                         // frame height in lines
    localparam int PAR_LATENCY   = 7;                          // recalc depth, cycles

    // low nibble of the command address
    localparam logic [3:0] REG_MODE        = 4'h0;  // {extra_pages[1:0], enable, !reset}
    localparam logic [3:0] REG_START_ADDR  = 4'h2;  // {row, col8} of frame start
    localparam logic [3:0] REG_FULL_WIDTH  = 4'h3;  // padded line pitch in 8-bursts
    localparam logic [3:0] REG_WINDOW_WH   = 4'h4;  // x = width, y = height
    localparam logic [3:0] REG_WINDOW_X0Y0 = 4'h5;  // window origin in the frame
    localparam logic [3:0] REG_START_XY    = 4'h6;  // first x/y relative to the window

    typedef struct packed {
        logic [15:0] y;
        logic [15:0] x;
    } xy_pair_t;

    typedef union packed {
        logic [31:0] word;  // flat view for address and mode
        xy_pair_t    xy;    // split view for window registers
    } cmd_word_u;

    typedef struct packed {
        logic [RC_BITS-1:0] start_addr;
        logic [FW_BITS:0]   full_width;
        logic [FW_BITS:0]   win_width;   // 1..0x2000
        logic [FH_BITS:0]   win_height;  // 1..0x10000
        logic [FW_BITS-1:0] win_x0;
        logic [FH_BITS-1:0] win_y0;
        logic [FW_BITS-1:0] start_x;
        logic [FH_BITS-1:0] start_y;
        logic               chn_en;
        logic               chn_rst;
        logic [1:0]         extra_pages;
    } scan_cfg_t;

    typedef struct packed {
        logic [FW_BITS-1:0] x;          // relative to window left
        logic [FH_BITS-1:0] y;          // relative to window top
        logic               continued;  // next transfer finishes a page split
    } scan_pos_t;

    typedef struct packed {
        logic [2:0]               bank;
        logic [ADDR_ROW_BITS-1:0] row;
        logic [COL8_BITS-1:0]     col;
        logic [XFER_BITS:0]       num128;  // 1..64
        logic                     partial;
        logic                     last_in_row;
        logic                     last_block;
    } xfer_req_t;

endpackage

`default_nettype wire

/* list.f */
common/scanline_pkg.sv
cmd_in/cmd_deser.sv
cmd_in/scanline_regs.sv
logic/xfer_calc.sv
logic/frame_seq.sv
logic/scanline_chan.sv
verif/tb_scanline.sv

/* logic/frame_seq.sv */
//##########################################################################
// frame walker: want/need/grant requests, page credit, pending and frame done
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module frame_seq (
    input  wire                        rst,        // clock
    input  wire                        mclk,       // async reset
    input  wire scanline_pkg::scan_cfg_t cfg,
    input  wire scanline_pkg::xfer_req_t req,
    input  wire                        calc_valid,
    input  wire                        param_wr,
    input  wire                        frame_start,
    input  wire                        next_page,  // consumer freed a buffer page
    input  wire                        xfer_grant,
    input  wire                        xfer_done,
    output scanline_pkg::scan_pos_t    pos,
    output logic                       recalc_go,
    output logic                       xfer_want,
    output logic                       xfer_need,
    output logic                       xfer_start,
    output logic [2:0]                 xfer_bank,
    output logic [scanline_pkg::ADDR_ROW_BITS-1:0] xfer_row,
    output logic [scanline_pkg::COL8_BITS-1:0]     xfer_col,
    output logic [scanline_pkg::XFER_BITS-1:0]     xfer_num128,  // 0 means 64
    output logic                       xfer_partial,
    output logic                       frame_done,
    output logic                       xfer_reset_page
);

    logic       busy_r;
    logic       chn_rst_d;     // to catch reset release
    logic       last_issued;   // last block of the window has started
    logic       pre_want;
    logic       start_full;    // start that consumes a buffer page
    logic [2:0] page_cntr;     // free buffer pages
    logic [1:0] pending;       // started, not yet done
    logic [1:0] pend_next;

    assign start_full   = xfer_start && !req.partial;
    assign pre_want     = busy_r && cfg.chn_en && calc_valid && !xfer_want &&
                          !xfer_start && !last_issued;
    assign recalc_go    = xfer_start || param_wr || frame_start || (chn_rst_d && !cfg.chn_rst);
    assign xfer_bank    = req.bank;
    assign xfer_row     = req.row;
    assign xfer_col     = req.col;
    assign xfer_num128  = req.num128[scanline_pkg::XFER_BITS-1:0];
    assign xfer_partial = req.partial;

    always_comb begin
        case ({xfer_start, xfer_done})
            2'b10:   pend_next = pending + 2'd1;
            2'b01:   pend_next = pending - 2'd1;
            default: pend_next = pending;
        endcase
    end

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            busy_r          <= 1'b0;
            chn_rst_d       <= 1'b1;
            xfer_reset_page <= 1'b1;  // mode is 0 after reset
            xfer_start      <= 1'b0;
            xfer_want       <= 1'b0;
            xfer_need       <= 1'b0;
            page_cntr       <= '0;
            pending         <= '0;
            last_issued     <= 1'b0;
            frame_done      <= 1'b0;
            pos             <= '0;
        end else begin
            chn_rst_d       <= cfg.chn_rst;
            xfer_reset_page <= cfg.chn_rst;
            xfer_start      <= xfer_grant && !cfg.chn_rst;

            if (cfg.chn_rst)      busy_r <= 1'b0;
            else if (frame_start) busy_r <= 1'b1;
            else if (frame_done)  busy_r <= 1'b0;

            if (cfg.chn_rst || xfer_grant) begin
                xfer_want <= 1'b0;
                xfer_need <= 1'b0;
            end else if (pre_want && (page_cntr > {1'b0, cfg.extra_pages})) begin
                xfer_want <= 1'b1;
                xfer_need <= page_cntr >= 3'd3;   // buffer nearly empty
            end

            if (frame_start)                   page_cntr <= 3'd4;
            else if (start_full && !next_page) page_cntr <= page_cntr - 3'd1;
            else if (!start_full && next_page) page_cntr <= page_cntr + 3'd1;

            if (cfg.chn_rst || !busy_r) pending <= '0;
            else                        pending <= pend_next;

            if (cfg.chn_rst || !busy_r) last_issued <= 1'b0;
            else if (xfer_start)        last_issued <= req.last_block;

            if (cfg.chn_rst || frame_start)
                frame_done <= 1'b0;
            else if (busy_r && last_issued && xfer_done && (pend_next == 2'd0))
                frame_done <= 1'b1;

            if (cfg.chn_rst || frame_start) begin
                pos.x         <= cfg.start_x;
                pos.y         <= cfg.start_y;
                pos.continued <= 1'b0;
            end else if (xfer_start) begin
                pos.x <= req.last_in_row ? '0 : pos.x + {6'd0, req.num128};
                if (req.last_in_row)
                    pos.y <= pos.y + 16'd1;
                pos.continued <= req.partial;  // split resumes next
            end
        end
    end

    a_want_busy : assert property (@(posedge rst) disable iff (mclk) xfer_want |-> busy_r);
    a_pend_wrap : assert property (@(posedge rst) disable iff (mclk)
        !(xfer_start && !xfer_done && (pending == 2'd3)) &&
        !(xfer_done && !xfer_start && (pending == 2'd0)));

endmodule

`default_nettype wire

/* logic/scanline_chan.sv */
//##########################################################################
// scan-line memory channel: command registers, recalc pipeline, request side
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module scanline_chan #(
    parameter logic [15:0] CMD_BASE = 16'h0120,
    parameter logic [15:0] CMD_MASK = 16'h03f0
) (
    input  wire         rst,              // clock
    input  wire         mclk,             // async reset
    input  wire [7:0]   cmd_ad,
    input  wire         cmd_stb,
    input  wire         frame_start,
    input  wire         next_page,
    output logic        frame_done,
    output logic        xfer_want,
    output logic        xfer_need,
    input  wire         xfer_grant,
    output logic        xfer_start,
    output logic [2:0]  xfer_bank,
    output logic [scanline_pkg::ADDR_ROW_BITS-1:0] xfer_row,
    output logic [scanline_pkg::COL8_BITS-1:0]     xfer_col,
    output logic [scanline_pkg::XFER_BITS-1:0]     xfer_num128,
    output logic        xfer_partial,
    input  wire         xfer_done,
    output logic        xfer_reset_page
);

    logic [3:0]                cmd_a;
    scanline_pkg::cmd_word_u   cmd_data;
    logic                      cmd_we;
    scanline_pkg::scan_cfg_t   cfg;
    logic                      param_wr;
    scanline_pkg::scan_pos_t   pos;
    logic                      recalc_go;
    scanline_pkg::xfer_req_t   req;
    logic                      calc_valid;

    cmd_deser #(.CMD_BASE(CMD_BASE), .CMD_MASK(CMD_MASK)) u_deser (
        .rst(rst), .mclk(mclk), .cmd_ad(cmd_ad), .cmd_stb(cmd_stb),
        .cmd_a(cmd_a), .cmd_data(cmd_data), .cmd_we(cmd_we));

    scanline_regs u_regs (
        .rst(rst), .mclk(mclk), .cmd_a(cmd_a), .cmd_data(cmd_data), .cmd_we(cmd_we),
        .cfg(cfg), .param_wr(param_wr));

    xfer_calc u_calc (
        .rst(rst), .mclk(mclk), .cfg(cfg), .pos(pos), .recalc_go(recalc_go),
        .req(req), .calc_valid(calc_valid));

    frame_seq u_seq (
        .rst(rst), .mclk(mclk), .cfg(cfg), .req(req), .calc_valid(calc_valid),
        .param_wr(param_wr), .frame_start(frame_start), .next_page(next_page),
        .xfer_grant(xfer_grant), .xfer_done(xfer_done), .pos(pos), .recalc_go(recalc_go),
        .xfer_want(xfer_want), .xfer_need(xfer_need), .xfer_start(xfer_start),
        .xfer_bank(xfer_bank), .xfer_row(xfer_row), .xfer_col(xfer_col),
        .xfer_num128(xfer_num128), .xfer_partial(xfer_partial),
        .frame_done(frame_done), .xfer_reset_page(xfer_reset_page));

endmodule

`default_nettype wire

/* logic/xfer_calc.sv */
//##########################################################################
// transfer recalculation pipeline: position to bank/row/col, count and split
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module xfer_calc (
    input  wire                      rst,        // clock
    input  wire                      mclk,       // async reset
    input  wire scanline_pkg::scan_cfg_t cfg,
    input  wire scanline_pkg::scan_pos_t pos,
    input  wire                      recalc_go,
    output scanline_pkg::xfer_req_t  req,
    output logic                     calc_valid
);

    localparam int LAT = scanline_pkg::PAR_LATENCY;
    localparam int FW  = scanline_pkg::FW_BITS;
    localparam int FH  = scanline_pkg::FH_BITS;
    localparam int XB  = scanline_pkg::XFER_BITS;
    localparam int C8  = scanline_pkg::COL8_BITS;
    localparam int RC  = scanline_pkg::RC_BITS;

    logic [LAT-2:0]     recalc_r;   // one-hot stage enables, pos settled by stage 0
    logic [LAT-1:0]     valid_r;    // fills with ones after each drop
    logic [FW-1:0]      frame_x;
    logic [FH-1:0]      frame_y;
    logic [FH:0]        next_y;
    logic [FW:0]        row_left;   // bursts to the window right edge
    logic [C8:0]        page_room;  // bursts to the DRAM page end, 1..128
    logic [XB:0]        lim;        // row_left clipped to 64
    logic [XB:0]        spill;
    logic [XB:0]        num;
    logic [XB-1:0]      leftover;   // second half of a split transfer
    logic               partial;
    logic               last_in_row;
    logic               last_block;
    logic [FH+FW-3:0]   mul_full;   // line8 * pitch, upper bits dropped
    logic [RC-1:0]      mul_rslt;
    logic [RC-1:0]      line_start;
    logic [RC-1:0]      row_col;
    logic               page_short;

    assign mul_full   = frame_y[FH-1:3] * cfg.full_width;
    assign page_short = page_room < {1'b0, lim};
    assign spill      = lim - page_room[XB:0];
    assign calc_valid = valid_r[LAT-1];

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            recalc_r <= '0;
            valid_r  <= '0;
        end else begin
            recalc_r <= cfg.chn_rst ? '0 : {recalc_r[LAT-3:0], recalc_go};
            if (recalc_go || cfg.chn_rst)
                valid_r <= '0;
            else
                valid_r <= {valid_r[LAT-2:0], 1'b1};
        end
    end

    always_ff @(posedge rst) begin
        if (recalc_r[0]) begin                      // frame coordinates
            frame_x  <= pos.x + cfg.win_x0;
            frame_y  <= pos.y + cfg.win_y0;
            next_y   <= {1'b0, pos.y} + 17'd1;
            row_left <= cfg.win_width - {1'b0, pos.x};
        end
        if (recalc_r[1]) begin                      // limits, multiplier
            page_room <= 8'd128 - {1'b0, frame_x[C8-1:0]};
            lim       <= (|row_left[FW:XB]) ? 7'd64 : row_left[XB:0];
            mul_rslt  <= mul_full[RC-1:0];
        end
        if (recalc_r[2]) begin                      // count and split, line start
            line_start <= cfg.start_addr + mul_rslt;
            if (pos.continued) begin
                num     <= {1'b0, leftover};
                partial <= 1'b0;
            end else if (page_short) begin
                num      <= page_room[XB:0];
                partial  <= 1'b1;
                leftover <= spill[XB-1:0];
            end else begin
                num     <= lim;
                partial <= 1'b0;
            end
        end
        if (recalc_r[3]) begin                      // end of row / frame
            last_in_row <= row_left == {{(FW-XB){1'b0}}, num};
            last_block  <= (next_y == cfg.win_height) && (row_left == {{(FW-XB){1'b0}}, num});
        end
        if (recalc_r[4])
            row_col <= line_start + {{(RC-FW){1'b0}}, frame_x};
        if (recalc_r[5]) begin                      // publish, held until next drop
            req.bank        <= frame_y[2:0];
            req.row         <= row_col[RC-1:C8];
            req.col         <= row_col[C8-1:0];
            req.num128      <= num;
            req.partial     <= partial;
            req.last_in_row <= last_in_row;
            req.last_block  <= last_block;
        end
    end

    a_num_range : assert property (@(posedge rst) disable iff (mclk)
        calc_valid |-> (req.num128 != '0) && (req.num128 <= 7'd64));

endmodule

`default_nettype wire

/* verif/scanline_testdata.txt */
// kind_xxb_rrrr_cc_00_nn_0p  kind 1 cmd: 1_000_aaaa_dddddddd  2 frame: bit0 withholds pages
// kind 3 transfer: bank b, row rrrr, col cc, num128 nn, partial p  kind 4 end of frame
1_000_0120_00000003
1_000_0122_00012345
1_000_0123_00000040
1_000_0124_00030028
1_000_0125_00050008
1_000_0126_00000000
2_000_0000_00000000
3_005_0246_4d_00_28_00
3_006_0246_4d_00_28_00
3_007_0246_4d_00_28_00
4_000_0000_00000000
// 150 wide window, page edge 28 bursts in
1_000_0122_00002000
1_000_0123_00000300
1_000_0124_00020096
1_000_0125_000e0064
2_000_0000_00000000
3_006_0046_64_00_1c_01
3_006_0047_00_00_24_00
3_006_0047_24_00_00_00
3_006_0047_64_00_16_00
3_007_0046_64_00_1c_01
3_007_0047_00_00_24_00
3_007_0047_24_00_00_00
3_007_0047_64_00_16_00
4_000_0000_00000000
// foreign base address, frame repeats
1_000_0224_00050010
2_000_0000_00000000
3_006_0046_64_00_1c_01
3_006_0047_00_00_24_00
3_006_0047_24_00_00_00
3_006_0047_64_00_16_00
3_007_0046_64_00_1c_01
3_007_0047_00_00_24_00
3_007_0047_24_00_00_00
3_007_0047_64_00_16_00
4_000_0000_00000000
// one extra page, next_page withheld
1_000_0120_00000007
1_000_0125_000e0000
2_000_0000_00000001
3_006_0046_00_00_00_00
3_006_0046_40_00_00_00
3_006_0047_00_00_16_00
3_007_0046_00_00_00_00
3_007_0046_40_00_00_00
3_007_0047_00_00_16_00
4_000_0000_00000000

/* verif/tb_scanline.sv */
//##########################################################################
// testbench for the scan-line channel: data-file commands, sequencer model
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_scanline;

    logic        rst  = 1'b0;        // clock, 8 ns
    logic        mclk = 1'b1;        // async reset, active high
    logic [7:0]  cmd_ad = 8'h00;
    logic        cmd_stb = 1'b0;
    logic        frame_start = 1'b0;
    logic        next_page = 1'b0;
    logic        xfer_grant = 1'b0;
    logic        xfer_done = 1'b0;
    logic        frame_done;
    logic        xfer_want;
    logic        xfer_need;
    logic        xfer_start;
    logic [2:0]  xfer_bank;
    logic [14:0] xfer_row;
    logic [6:0]  xfer_col;
    logic [5:0]  xfer_num128;
    logic        xfer_partial;
    logic        xfer_reset_page;

    logic [63:0] stim [0:63];        // {kind, fields}, see the data file
    logic [31:0] seed = 32'h8707;
    int          cycle_cnt = 0;
    int          limit = 100000;     // replaced once the records are counted
    int          grant_wait = 0;     // cycles until the next grant
    int          done_wait = 0;      // cycles until the next done
    logic        done_full = 1'b0;   // running transfer frees a page
    logic        fire_done;
    int          page_owed = 0;      // next_page pulses not yet given
    logic        hold_pages = 1'b0;  // back-pressure test in progress
    int          starts_in_frame = 0;
    int          credit = 0;         // free buffer pages as the DUT should count them
    int          credit_prev = 0;    // credit one cycle back
    logic        want_prev = 1'b0;

    scanline_chan DUT (
        .rst(rst), .mclk(mclk), .cmd_ad(cmd_ad), .cmd_stb(cmd_stb),
        .frame_start(frame_start), .next_page(next_page), .frame_done(frame_done),
        .xfer_want(xfer_want), .xfer_need(xfer_need), .xfer_grant(xfer_grant),
        .xfer_start(xfer_start), .xfer_bank(xfer_bank), .xfer_row(xfer_row),
        .xfer_col(xfer_col), .xfer_num128(xfer_num128), .xfer_partial(xfer_partial),
        .xfer_done(xfer_done), .xfer_reset_page(xfer_reset_page));

    initial begin
        forever #4 rst = ~rst;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        lcg = s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // six bytes: address low/high, then D0..D3
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        int          i;
        bytes = {data, addr};
        for (i = 0; i < 6; i++) begin
            cmd_ad  <= bytes[i*8 +: 8];
            cmd_stb <= (i == 0);
            @(posedge rst);
        end
        cmd_stb <= 1'b0;
        cmd_ad  <= 8'h00;
        repeat (3) @(posedge rst);  // write strobe, then param_wr
    endtask

    // back-pressure: credit is used up, nothing may be requested
    task automatic watch_stall();
        repeat (50) begin
            @(posedge rst);
            check(xfer_want, 1'b0, "want while out of pages");
            check(xfer_start, 1'b0, "start while out of pages");
        end
        hold_pages <= 1'b0;  // the owed next_page pulses follow
        do begin
            @(posedge rst);
            check(xfer_want, 1'b0, "want before the first next_page");
        end while (next_page !== 1'b1);
    endtask

    always @(posedge rst) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= limit) begin
            $display("Timeout: the DUT did not respond within %0d cycles", limit);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    // memory sequencer model
    always @(posedge rst) begin
        xfer_grant <= 1'b0;
        xfer_done  <= 1'b0;
        next_page  <= 1'b0;
        if (grant_wait != 0) begin
            grant_wait <= grant_wait - 1;
            if (grant_wait == 1)
                xfer_grant <= 1'b1;
        end else if (xfer_want && !xfer_grant) begin
            seed = lcg(seed);
            grant_wait <= 1 + int'(seed[17:16]);  // 1..4 cycles
        end
        fire_done = (done_wait == 1) && !xfer_start;
        if (xfer_start) begin
            seed = lcg(seed);
            done_wait <= 2 + int'(seed[17:16]);
            done_full <= !xfer_partial;
        end else if (done_wait != 0) begin
            done_wait <= done_wait - 1;
            if (done_wait == 1)
                xfer_done <= 1'b1;
        end
        if (fire_done && done_full)
            page_owed <= page_owed + 1;
        else if (!hold_pages && (page_owed != 0) && !next_page) begin
            next_page <= 1'b1;  // one page freed per pulse
            page_owed <= page_owed - 1;
        end

        // need goes with a request made while 3 or more pages are free
        if (xfer_want && !want_prev)
            check(xfer_need, credit_prev >= 3, "need with a new request");
        want_prev   <= xfer_want;
        credit_prev <= credit;
        if (frame_start)
            credit <= 4;
        else
            credit <= credit + (next_page ? 1 : 0) - ((xfer_start && !xfer_partial) ? 1 : 0);
    end

    initial begin
        int          idx;
        int          nrec;
        logic [63:0] rec;
        logic [3:0]  kind;
        logic        first_frame;
        logic        done_prev;
        first_frame = 1'b1;
        done_prev   = 1'b0;
        for (idx = 0; idx < 64; idx++)
            stim[idx] = 64'h0;
        $readmemh("verif/scanline_testdata.txt", stim);
        nrec = 0;
        while ((nrec < 64) && (stim[nrec][63:60] != 4'h0))
            nrec++;
        limit = nrec * 200;

        repeat (8) @(posedge rst);
        mclk <= 1'b0;
        repeat (2) @(posedge rst);
        check(xfer_want, 1'b0, "want after reset");
        check(xfer_need, 1'b0, "need after reset");
        check(xfer_start, 1'b0, "start after reset");
        check(frame_done, 1'b0, "frame_done after reset");
        check(xfer_reset_page, 1'b1, "reset_page after reset");

        for (idx = 0; idx < nrec; idx++) begin
            rec  = stim[idx];
            kind = rec[63:60];
            case (kind)
                4'h1: send_cmd(rec[47:32], rec[31:0]);
                4'h2: begin
                    if (!first_frame)
                        check(frame_done, 1'b1, "frame_done held until frame_start");
                    check(xfer_reset_page, 1'b0, "reset_page with channel enabled");
                    first_frame = 1'b0;
                    starts_in_frame = 0;
                    hold_pages  <= rec[0];
                    frame_start <= 1'b1;
                    @(posedge rst);
                    frame_start <= 1'b0;
                    @(posedge rst);
                    check(frame_done, 1'b0, "frame_done after frame_start");
                end
                4'h3: begin
                    do begin
                        @(posedge rst);
                        check(frame_done, 1'b0, "frame_done before last transfer");
                    end while (xfer_start !== 1'b1);
                    check(xfer_bank, rec[50:48], "bank");
                    check(xfer_row, rec[46:32], "row");
                    check(xfer_col, rec[30:24], "col");
                    check(xfer_num128, rec[13:8], "num128");
                    check(xfer_partial, rec[0], "partial");
                    starts_in_frame++;
                    if (hold_pages && (starts_in_frame == 3))
                        watch_stall();
                end
                4'h4: begin
                    done_prev = 1'b0;
                    while (frame_done !== 1'b1) begin
                        done_prev = xfer_done;  // frame_done follows the last done
                        @(posedge rst);
                        check(xfer_start, 1'b0, "start beyond the window");
                    end
                    check(done_prev, 1'b1, "done in the cycle before frame_done");
                    repeat (4) @(posedge rst);
                end
                default: check(kind, 4'h1, "record kind in data file");
            endcase
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
